// ==== source/id_defs.svh ====
////////////////////////////////////////////////////////////
// decode/execute core constants
// widths, opcode and function fields, PAL codes
////////////////////////////////////////////////////////////
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define XLEN       64            // datapath width
`define ZERO_REG   5'd31         // hardwired zero register
`define CPU_ID     64'h0         // whami return value
`define NOOP_INST  32'h47ff_041f // bis r31,r31,r31 after reset

// major opcodes, inst[31:26]
`define PAL_INST   6'h00
`define LDA_INST   6'h08
`define INTA_GRP   6'h10
`define INTL_GRP   6'h11
`define INTS_GRP   6'h12
`define INTM_GRP   6'h13
`define JSR_GRP    6'h1a
`define LDQ_INST   6'h29
`define LDQ_L_INST 6'h2b
`define STQ_INST   6'h2d
`define STQ_C_INST 6'h2f
`define BR_INST    6'h30
`define BSR_INST   6'h34
`define BEQ_INST   6'h39
`define BLT_INST   6'h3a
`define BLE_INST   6'h3b
`define BNE_INST   6'h3d
`define BGE_INST   6'h3e
`define BGT_INST   6'h3f

// function codes, inst[11:5]
`define ADDQ_INST   7'h20 // arith group
`define SUBQ_INST   7'h29
`define CMPEQ_INST  7'h2d
`define CMPULT_INST 7'h1d
`define CMPULE_INST 7'h3d
`define CMPLT_INST  7'h4d
`define CMPLE_INST  7'h6d
`define AND_INST    7'h00 // logic group
`define BIC_INST    7'h08
`define BIS_INST    7'h20
`define ORNOT_INST  7'h28
`define XOR_INST    7'h40
`define EQV_INST    7'h48
`define SRL_INST    7'h34 // shift group
`define SLL_INST    7'h39
`define SRA_INST    7'h3c
`define MULQ_INST   7'h20 // multiply group

// PAL function field, inst[25:0]
`define PAL_HALT  26'h555
`define PAL_WHAMI 26'h03c

`endif

// ==== source/id_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types for the decode/execute core
// operand selects, alu ops, stage packets
////////////////////////////////////////////////////////////
`include "id_defs.svh"

package id_pkg;

  typedef enum logic [1:0] {
    IS_REGA,     // register a
    IS_MEM_DISP, // sign extended 16b displacement
    IS_NPC,      // next pc
    IS_NOT3      // ~3, word align mask for jumps
  } alu_opa_select_e;

  typedef enum logic [1:0] {
    IS_REGB,     // register b
    IS_ALU_IMM,  // 8b literal
    IS_BR_DISP   // 21b branch displacement << 2
  } alu_opb_select_e;

  typedef enum logic [1:0] {
    DEST_NONE,
    DEST_IS_REGA,
    DEST_IS_REGC
  } dest_reg_sel_e;

  typedef enum logic [4:0] {
    ALU_ADDQ,  ALU_SUBQ,  ALU_AND,    ALU_BIC,
    ALU_BIS,   ALU_ORNOT, ALU_XOR,    ALU_EQV,
    ALU_SRL,   ALU_SLL,   ALU_SRA,    ALU_MULQ,
    ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE,  ALU_CMPULT,
    ALU_CMPULE
  } alu_func_e;

  ////////////////////////////////////////////////////////////
  // stage packets
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              valid;
    logic [31:0]       inst;
    logic [`XLEN-1:0]  npc;
  } f_d_packet_t; // fetch to decode, 97b

  typedef struct packed {
    logic              wr_en;
    logic [4:0]        wr_idx;
    logic [`XLEN-1:0]  wr_data;
  } r_reg_packet_t; // regfile write port, 70b

  typedef struct packed {
    logic              valid;
    logic [31:0]       inst;
    logic [`XLEN-1:0]  npc;
    logic [`XLEN-1:0]  rega_value;
    logic [`XLEN-1:0]  regb_value;
    alu_opa_select_e   opa_select;
    alu_opb_select_e   opb_select;
    alu_func_e         alu_func;
    logic [4:0]        dest_reg_idx;
    logic              rd_mem, wr_mem, ldl_mem, stc_mem;
    logic              cond_branch, uncond_branch;
    logic              halt, cpuid, illegal;
  } s_x_packet_t; // decode to execute

  typedef struct packed {
    logic              valid;
    logic              halt;
    logic              illegal;
    logic              take_branch;
    logic              mem_access;
    logic [`XLEN-1:0]  result;   // address, target or value
    r_reg_packet_t     wb;
    logic [`XLEN-1:0]  npc;
  } x_w_packet_t; // execute to writeback

endpackage

// ==== source/decoder.sv ====
////////////////////////////////////////////////////////////
// instruction decoder
// purely combinational, maps an instruction word to
// datapath controls; defaults give a noop
////////////////////////////////////////////////////////////
`include "id_defs.svh"

module decoder (
  input  logic [31:0]                inst,
  input  logic                       valid_inst_in, // low forces noop outputs
  output id_pkg::alu_opa_select_e    opa_select,
  output id_pkg::alu_opb_select_e    opb_select,
  output id_pkg::dest_reg_sel_e      dest_reg,
  output id_pkg::alu_func_e          alu_func,
  output logic                       rd_mem,
  output logic                       wr_mem,
  output logic                       ldl_mem,
  output logic                       stc_mem,
  output logic                       cond_branch,
  output logic                       uncond_branch,
  output logic                       halt,
  output logic                       cpuid,
  output logic                       illegal,
  output logic                       valid_inst    // halts stay valid
);

  assign valid_inst = valid_inst_in && !illegal;

  always_comb
  begin
    // noop defaults
    opa_select    = id_pkg::IS_REGA;
    opb_select    = id_pkg::IS_REGB;
    alu_func      = id_pkg::ALU_ADDQ;
    dest_reg      = id_pkg::DEST_NONE;
    rd_mem        = 1'b0;
    wr_mem        = 1'b0;
    ldl_mem       = 1'b0;
    stc_mem       = 1'b0;
    cond_branch   = 1'b0;
    uncond_branch = 1'b0;
    halt          = 1'b0;
    cpuid         = 1'b0;
    illegal       = 1'b0;
    if (valid_inst_in)
    begin
      case (inst[31:26])
        `PAL_INST:
        begin
          if (inst[25:0] == `PAL_HALT)
            halt = 1'b1;
          else if (inst[25:0] == `PAL_WHAMI)
          begin
            cpuid    = 1'b1;
            dest_reg = id_pkg::DEST_IS_REGA; // ra field is r0
          end
          else
            illegal = 1'b1;
        end

        ////////////////////////////////////////////////////////////
        // operate format, rc = ra op (rb | lit)
        ////////////////////////////////////////////////////////////
        `INTA_GRP, `INTL_GRP, `INTS_GRP, `INTM_GRP:
        begin
          opb_select = inst[12] ? id_pkg::IS_ALU_IMM : id_pkg::IS_REGB;
          dest_reg   = id_pkg::DEST_IS_REGC;
          case (inst[31:26])
            `INTA_GRP:
              case (inst[11:5])
                `ADDQ_INST:   alu_func = id_pkg::ALU_ADDQ;
                `SUBQ_INST:   alu_func = id_pkg::ALU_SUBQ;
                `CMPEQ_INST:  alu_func = id_pkg::ALU_CMPEQ;
                `CMPLT_INST:  alu_func = id_pkg::ALU_CMPLT;
                `CMPLE_INST:  alu_func = id_pkg::ALU_CMPLE;
                `CMPULT_INST: alu_func = id_pkg::ALU_CMPULT;
                `CMPULE_INST: alu_func = id_pkg::ALU_CMPULE;
                default:      illegal  = 1'b1; // longword forms etc
              endcase
            `INTL_GRP:
              case (inst[11:5])
                `AND_INST:    alu_func = id_pkg::ALU_AND;
                `BIC_INST:    alu_func = id_pkg::ALU_BIC;
                `BIS_INST:    alu_func = id_pkg::ALU_BIS;
                `ORNOT_INST:  alu_func = id_pkg::ALU_ORNOT;
                `XOR_INST:    alu_func = id_pkg::ALU_XOR;
                `EQV_INST:    alu_func = id_pkg::ALU_EQV;
                default:      illegal  = 1'b1; // cmov not here
              endcase
            `INTS_GRP:
              case (inst[11:5])
                `SRL_INST:    alu_func = id_pkg::ALU_SRL;
                `SLL_INST:    alu_func = id_pkg::ALU_SLL;
                `SRA_INST:    alu_func = id_pkg::ALU_SRA;
                default:      illegal  = 1'b1;
              endcase
            default: // multiply group
              if (inst[11:5] == `MULQ_INST)
                alu_func = id_pkg::ALU_MULQ;
              else
                illegal = 1'b1;
          endcase
        end

        `JSR_GRP:
        begin
          // jmp/jsr/ret share one form, target = rb & ~3
          opa_select    = id_pkg::IS_NOT3;
          alu_func      = id_pkg::ALU_AND;
          dest_reg      = id_pkg::DEST_IS_REGA; // link
          uncond_branch = 1'b1;
        end

        `LDA_INST, `LDQ_INST, `LDQ_L_INST, `STQ_INST, `STQ_C_INST:
        begin
          opa_select = id_pkg::IS_MEM_DISP; // disp + rb
          dest_reg   = id_pkg::DEST_IS_REGA;
          rd_mem     = (inst[31:26] == `LDQ_INST) || (inst[31:26] == `LDQ_L_INST);
          ldl_mem    = (inst[31:26] == `LDQ_L_INST);
          wr_mem     = (inst[31:26] == `STQ_INST) || (inst[31:26] == `STQ_C_INST);
          stc_mem    = (inst[31:26] == `STQ_C_INST);
          if (inst[31:26] == `STQ_INST)
            dest_reg = id_pkg::DEST_NONE; // plain store writes nothing
        end

        `BR_INST, `BSR_INST:
        begin
          opa_select    = id_pkg::IS_NPC;
          opb_select    = id_pkg::IS_BR_DISP;
          dest_reg      = id_pkg::DEST_IS_REGA; // link reg
          uncond_branch = 1'b1;
        end

        `BEQ_INST, `BLT_INST, `BLE_INST, `BNE_INST, `BGE_INST, `BGT_INST:
        begin
          opa_select  = id_pkg::IS_NPC;
          opb_select  = id_pkg::IS_BR_DISP;
          cond_branch = 1'b1;
        end

        default: illegal = 1'b1; // fp, blbc/blbs, unknown
      endcase
    end
  end

endmodule

// ==== source/regfile.sv ====
////////////////////////////////////////////////////////////
// integer register file
// 2 async reads, 1 write at the clock edge, r31 reads 0
////////////////////////////////////////////////////////////
`include "id_defs.svh"

module regfile (
  input  logic                  clock,
  input  logic [4:0]            rda_idx,
  input  logic [4:0]            rdb_idx,
  output logic [`XLEN-1:0]      rda_out,
  output logic [`XLEN-1:0]      rdb_out,
  input  id_pkg::r_reg_packet_t wb
);

  logic [`XLEN-1:0] regs [0:30]; // r0..r30, no storage for r31

  // no bypass, a write shows up the cycle after the edge
  assign rda_out = (rda_idx == `ZERO_REG) ? '0 : regs[rda_idx];
  assign rdb_out = (rdb_idx == `ZERO_REG) ? '0 : regs[rdb_idx];

  always_ff @(posedge clock)
  begin
    if (wb.wr_en && (wb.wr_idx != `ZERO_REG))
      regs[wb.wr_idx] <= wb.wr_data; // r31 writes dropped
  end

endmodule

// ==== source/id_stage.sv ====
////////////////////////////////////////////////////////////
// decode stage
// decoder plus register reads and dest index select
////////////////////////////////////////////////////////////
`include "id_defs.svh"

module id_stage (
  input  logic                  clock,
  input  id_pkg::f_d_packet_t   f_d_in,
  input  id_pkg::r_reg_packet_t wb_packet, // from EX/WB
  output id_pkg::s_x_packet_t   s_x_out
);

  id_pkg::dest_reg_sel_e dest_sel;

  // register fields
  logic [4:0] ra_idx;
  logic [4:0] rb_idx;
  logic [4:0] rc_idx;

  assign ra_idx = f_d_in.inst[25:21];
  assign rb_idx = f_d_in.inst[20:16];
  assign rc_idx = f_d_in.inst[4:0];

  assign s_x_out.inst = f_d_in.inst;
  assign s_x_out.npc  = f_d_in.npc;

  regfile u_regfile (
    .clock   (clock),
    .rda_idx (ra_idx),
    .rdb_idx (rb_idx),
    .rda_out (s_x_out.rega_value),
    .rdb_out (s_x_out.regb_value),
    .wb      (wb_packet)
  );

  decoder u_decoder (
    .inst          (f_d_in.inst),
    .valid_inst_in (f_d_in.valid),
    .opa_select    (s_x_out.opa_select),
    .opb_select    (s_x_out.opb_select),
    .dest_reg      (dest_sel),
    .alu_func      (s_x_out.alu_func),
    .rd_mem        (s_x_out.rd_mem),
    .wr_mem        (s_x_out.wr_mem),
    .ldl_mem       (s_x_out.ldl_mem),
    .stc_mem       (s_x_out.stc_mem),
    .cond_branch   (s_x_out.cond_branch),
    .uncond_branch (s_x_out.uncond_branch),
    .halt          (s_x_out.halt),
    .cpuid         (s_x_out.cpuid),
    .illegal       (s_x_out.illegal),
    .valid_inst    (s_x_out.valid)
  );

  always_comb
  begin
    case (dest_sel)
      id_pkg::DEST_IS_REGA: s_x_out.dest_reg_idx = ra_idx;
      id_pkg::DEST_IS_REGC: s_x_out.dest_reg_idx = rc_idx;
      default:              s_x_out.dest_reg_idx = `ZERO_REG; // no write
    endcase
  end

endmodule

// ==== source/ex_stage.sv ====
////////////////////////////////////////////////////////////
// execute stage
// ID/EX register, operand muxes, alu, branch test and
// the EX/WB register that feeds writeback
////////////////////////////////////////////////////////////
`include "id_defs.svh"

module ex_stage (
  input  logic                clock,
  input  logic                rst_n,
  input  id_pkg::s_x_packet_t s_x_in,
  output id_pkg::x_w_packet_t x_w_out
);

  id_pkg::s_x_packet_t id_ex;   // ID/EX register
  id_pkg::x_w_packet_t ex_wb;   // EX/WB register
  logic [`XLEN-1:0] opa, opb, alu_result;
  logic             cond_true;
  logic             wr_en;

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      id_ex      <= '0;         // bubble, every control off
      id_ex.inst <= `NOOP_INST;
    end
    else
      id_ex <= s_x_in;
  end

  ////////////////////////////////////////////////////////////
  // operands and alu
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    case (id_ex.opa_select)
      id_pkg::IS_MEM_DISP: opa = {{(`XLEN-16){id_ex.inst[15]}}, id_ex.inst[15:0]};
      id_pkg::IS_NPC:      opa = id_ex.npc;
      id_pkg::IS_NOT3:     opa = ~{{(`XLEN-2){1'b0}}, 2'b11};
      default:             opa = id_ex.rega_value;
    endcase
    case (id_ex.opb_select)
      id_pkg::IS_ALU_IMM:  opb = {{(`XLEN-8){1'b0}}, id_ex.inst[20:13]}; // literal
      id_pkg::IS_BR_DISP:  opb = {{(`XLEN-23){id_ex.inst[20]}}, id_ex.inst[20:0], 2'b00};
      default:             opb = id_ex.regb_value;
    endcase
  end

  always_comb
  begin
    case (id_ex.alu_func)
      id_pkg::ALU_SUBQ:   alu_result = opa - opb;
      id_pkg::ALU_AND:    alu_result = opa & opb;
      id_pkg::ALU_BIC:    alu_result = opa & ~opb;
      id_pkg::ALU_BIS:    alu_result = opa | opb;
      id_pkg::ALU_ORNOT:  alu_result = opa | ~opb;
      id_pkg::ALU_XOR:    alu_result = opa ^ opb;
      id_pkg::ALU_EQV:    alu_result = opa ^ ~opb;
      id_pkg::ALU_SRL:    alu_result = opa >> opb[5:0];  // low 6 bits only
      id_pkg::ALU_SLL:    alu_result = opa << opb[5:0];
      id_pkg::ALU_SRA:    alu_result = $signed(opa) >>> opb[5:0];
      id_pkg::ALU_MULQ:   alu_result = opa * opb;        // low half kept
      id_pkg::ALU_CMPEQ:  alu_result = {{(`XLEN-1){1'b0}}, opa == opb};
      id_pkg::ALU_CMPLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
      id_pkg::ALU_CMPLE:  alu_result = {{(`XLEN-1){1'b0}}, $signed(opa) <= $signed(opb)};
      id_pkg::ALU_CMPULT: alu_result = {{(`XLEN-1){1'b0}}, opa < opb};
      id_pkg::ALU_CMPULE: alu_result = {{(`XLEN-1){1'b0}}, opa <= opb};
      default:            alu_result = opa + opb;        // addq, addresses
    endcase
  end

  // branch condition on ra, inst[28:26]
  always_comb
  begin
    case (id_ex.inst[28:26])
      3'b001:  cond_true = (id_ex.rega_value == '0);                          // beq
      3'b010:  cond_true = id_ex.rega_value[`XLEN-1];                         // blt
      3'b011:  cond_true = id_ex.rega_value[`XLEN-1] || (id_ex.rega_value == '0);
      3'b101:  cond_true = (id_ex.rega_value != '0);                          // bne
      3'b110:  cond_true = !id_ex.rega_value[`XLEN-1];                        // bge
      3'b111:  cond_true = !id_ex.rega_value[`XLEN-1] && (id_ex.rega_value != '0);
      default: cond_true = 1'b0; // low bit forms, decoded illegal
    endcase
  end

  // loads and plain stores never write, stq_c reports success
  assign wr_en = id_ex.valid && !id_ex.rd_mem && !(id_ex.wr_mem && !id_ex.stc_mem)
                 && (id_ex.dest_reg_idx != `ZERO_REG);

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      ex_wb.valid       <= 1'b0;
      ex_wb.halt        <= 1'b0;
      ex_wb.illegal     <= 1'b0;
      ex_wb.take_branch <= 1'b0;
      ex_wb.mem_access  <= 1'b0;
      ex_wb.wb.wr_en    <= 1'b0;
    end
    else
    begin
      ex_wb.valid       <= id_ex.valid;
      ex_wb.halt        <= id_ex.halt;
      ex_wb.illegal     <= id_ex.illegal;
      ex_wb.take_branch <= id_ex.valid && (id_ex.uncond_branch ||
                                           (id_ex.cond_branch && cond_true));
      ex_wb.mem_access  <= id_ex.rd_mem || id_ex.wr_mem;
      ex_wb.wb.wr_en    <= wr_en;
    end
    // payload, no reset
    ex_wb.result    <= alu_result;
    ex_wb.npc       <= id_ex.npc;
    ex_wb.wb.wr_idx <= id_ex.dest_reg_idx;
    if (id_ex.uncond_branch)
      ex_wb.wb.wr_data <= id_ex.npc;                       // link address
    else if (id_ex.cpuid)
      ex_wb.wb.wr_data <= `CPU_ID;
    else if (id_ex.stc_mem)
      ex_wb.wb.wr_data <= {{(`XLEN-1){1'b0}}, 1'b1};       // stq_c always succeeds
    else
      ex_wb.wb.wr_data <= alu_result;
  end

  assign x_w_out = ex_wb;

endmodule

// ==== source/core_top.sv ====
////////////////////////////////////////////////////////////
// decode/execute core top
// id_stage feeds ex_stage, writeback loops to regfile
////////////////////////////////////////////////////////////
module core_top (
  input  logic                clock,
  input  logic                rst_n,
  input  id_pkg::f_d_packet_t f_d_in,  // one inst or bubble per cycle
  output id_pkg::x_w_packet_t x_w_out
);

  id_pkg::s_x_packet_t s_x_packet; // decode result, comb

  id_stage u_id_stage (
    .clock     (clock),
    .f_d_in    (f_d_in),
    .wb_packet (x_w_out.wb),       // write port from EX/WB
    .s_x_out   (s_x_packet)
  );

  ex_stage u_ex_stage (
    .clock   (clock),
    .rst_n   (rst_n),
    .s_x_in  (s_x_packet),
    .x_w_out (x_w_out)
  );

endmodule

// ==== testbench/core_asserts.sv ====
////////////////////////////////////////////////////////////
// core checker
// shadow register model, two-deep instruction history and
// result checks on the writeback packet, bound into core_top
////////////////////////////////////////////////////////////
`include "id_defs.svh"

module core_asserts (
  input logic                clock,
  input logic                rst_n,
  input id_pkg::f_d_packet_t f_d_in,
  input id_pkg::x_w_packet_t x_w_out
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int W = `XLEN;

  typedef struct packed {
    logic             valid;
    logic [31:0]      inst;
    logic [`XLEN-1:0] npc;
    logic [`XLEN-1:0] a;   // shadow ra at decode
    logic [`XLEN-1:0] b;   // shadow rb at decode
  } stage_t;

  logic [`XLEN-1:0] shadow [0:31]; // r31 never written, stays 0
  stage_t           s1;
  stage_t           s2;            // lines up with x_w_out
  logic [5:0]       op;
  logic             is_oper, is_cbr, is_mem, is_legal;
  logic [`XLEN:0]   oper_exp;      // msb set for a known pair
  logic [`XLEN-1:0] disp16, mem_addr, br_target;
  int               fail_count = 0;

  ////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////
  function automatic logic [`XLEN:0] oper_eval(input logic [31:0]      inst,
                                               input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] rb_val);
    logic [`XLEN-1:0] b;
    b = inst[12] ? W'(inst[20:13]) : rb_val; // 8b literal, zero extended
    case ({inst[31:26], inst[11:5]})
      {`INTA_GRP, `ADDQ_INST}:   return {1'b1, a + b};
      {`INTA_GRP, `SUBQ_INST}:   return {1'b1, a - b};
      {`INTA_GRP, `CMPEQ_INST}:  return {1'b1, W'(a == b)};
      {`INTA_GRP, `CMPLT_INST}:  return {1'b1, W'($signed(a) < $signed(b))};
      {`INTA_GRP, `CMPLE_INST}:  return {1'b1, W'($signed(a) <= $signed(b))};
      {`INTA_GRP, `CMPULT_INST}: return {1'b1, W'(a < b)};
      {`INTA_GRP, `CMPULE_INST}: return {1'b1, W'(a <= b)};
      {`INTL_GRP, `AND_INST}:    return {1'b1, a & b};
      {`INTL_GRP, `BIC_INST}:    return {1'b1, a & ~b};
      {`INTL_GRP, `BIS_INST}:    return {1'b1, a | b};
      {`INTL_GRP, `ORNOT_INST}:  return {1'b1, a | ~b};
      {`INTL_GRP, `XOR_INST}:    return {1'b1, a ^ b};
      {`INTL_GRP, `EQV_INST}:    return {1'b1, ~(a ^ b)};
      {`INTS_GRP, `SRL_INST}:    return {1'b1, a >> b[5:0]};
      {`INTS_GRP, `SLL_INST}:    return {1'b1, a << b[5:0]};
      {`INTS_GRP, `SRA_INST}:    return {1'b1, W'($signed(a) >>> b[5:0])};
      {`INTM_GRP, `MULQ_INST}:   return {1'b1, a * b};   // low 64 bits
      default:                   return '0;
    endcase
  endfunction

  function automatic logic cond_holds(input logic [5:0] opc, input logic [`XLEN-1:0] a);
    case (opc)
      `BEQ_INST: return a == 0;
      `BLT_INST: return $signed(a) < 0;
      `BLE_INST: return $signed(a) <= 0;
      `BNE_INST: return a != 0;
      `BGE_INST: return $signed(a) >= 0;
      default:   return $signed(a) > 0; // bgt
    endcase
  endfunction

  task automatic report_failure(input string msg);
    fail_count++;
    $error("CHECK FAILED t=%0t %s", $time, msg);
  endtask

  // shadow regfile follows the writeback port, history follows the input
  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
        shadow[i] <= '0;
      s1 <= '0;
      s2 <= '0;
    end
    else
    begin
      if (x_w_out.wb.wr_en && x_w_out.wb.wr_idx != `ZERO_REG)
        shadow[x_w_out.wb.wr_idx] <= x_w_out.wb.wr_data;
      s1 <= {f_d_in.valid, f_d_in.inst, f_d_in.npc,
             shadow[f_d_in.inst[25:21]], shadow[f_d_in.inst[20:16]]};
      s2 <= s1;
    end
  end

  assign op        = s2.inst[31:26];
  assign is_oper   = op inside {`INTA_GRP, `INTL_GRP, `INTS_GRP, `INTM_GRP};
  assign is_cbr    = op inside {`BEQ_INST, `BLT_INST, `BLE_INST, `BNE_INST, `BGE_INST, `BGT_INST};
  assign is_mem    = op inside {`LDQ_INST, `LDQ_L_INST, `STQ_INST, `STQ_C_INST};
  assign oper_exp  = oper_eval(s2.inst, s2.a, s2.b);
  assign disp16    = W'($signed(s2.inst[15:0]));
  assign mem_addr  = s2.b + disp16;
  assign br_target = s2.npc + W'($signed({s2.inst[20:0], 2'b00}));

  always_comb
  begin
    case (op)
      `PAL_INST:
        is_legal = (s2.inst[25:0] == `PAL_HALT) || (s2.inst[25:0] == `PAL_WHAMI);
      `INTA_GRP, `INTL_GRP, `INTS_GRP, `INTM_GRP:
        is_legal = oper_exp[`XLEN];
      `JSR_GRP, `LDA_INST, `LDQ_INST, `LDQ_L_INST, `STQ_INST, `STQ_C_INST,
      `BR_INST, `BSR_INST, `BEQ_INST, `BLT_INST, `BLE_INST, `BNE_INST,
      `BGE_INST, `BGT_INST:
        is_legal = 1'b1;
      default:
        is_legal = 1'b0; // fp, blbc/blbs, reserved
    endcase
  end

  ////////////////////////////////////////////////////////////
  // checks, two cycles after the instruction was applied
  ////////////////////////////////////////////////////////////
  chk_idle: assert property (@(posedge clock) disable iff (!rst_n)
    !s2.valid |-> !x_w_out.valid && !x_w_out.wb.wr_en && !x_w_out.halt && !x_w_out.take_branch)
    else report_failure("bubble left a live writeback packet");

  // npc rides along, valid only for legal words
  chk_pass: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid |-> x_w_out.npc == s2.npc && x_w_out.valid == is_legal)
    else report_failure("npc or valid not passed through");

  chk_lda: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid && op == `LDA_INST && s2.inst[20:16] == `ZERO_REG |->
      x_w_out.result == disp16 && x_w_out.wb.wr_data == disp16 &&
      x_w_out.wb.wr_idx == s2.inst[25:21] &&
      x_w_out.wb.wr_en == (s2.inst[25:21] != `ZERO_REG))
    else report_failure("lda value or index");

  chk_oper: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid && is_oper && oper_exp[`XLEN] |->
      x_w_out.result == oper_exp[`XLEN-1:0] && x_w_out.wb.wr_data == oper_exp[`XLEN-1:0] &&
      x_w_out.wb.wr_idx == s2.inst[4:0] && x_w_out.wb.wr_en == (s2.inst[4:0] != `ZERO_REG))
    else report_failure("operate result or rc index");

  chk_cbr: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid && is_cbr |->
      x_w_out.take_branch == cond_holds(op, s2.a) && x_w_out.result == br_target)
    else report_failure("conditional branch outcome or target");

  chk_br: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid && (op == `BR_INST || op == `BSR_INST) |->
      x_w_out.take_branch && x_w_out.result == br_target && x_w_out.wb.wr_data == s2.npc)
    else report_failure("br/bsr target or link");

  chk_jsr: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid && op == `JSR_GRP |->
      x_w_out.take_branch && x_w_out.result == (s2.b & ~W'(3)) &&
      x_w_out.wb.wr_data == s2.npc)
    else report_failure("jump target or link");

  chk_mem: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid && is_mem |->
      x_w_out.mem_access && x_w_out.result == mem_addr &&
      (op == `STQ_C_INST ? x_w_out.wb.wr_data == 1 : !x_w_out.wb.wr_en))
    else report_failure("memory address or write enable");

  chk_illegal: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid && !is_legal |-> x_w_out.illegal && !x_w_out.valid && !x_w_out.wb.wr_en)
    else report_failure("illegal word not flagged");

  chk_halt: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid && s2.inst == {`PAL_INST, `PAL_HALT} |-> x_w_out.halt && !x_w_out.wb.wr_en)
    else report_failure("halt not flagged");

  chk_whami: assert property (@(posedge clock) disable iff (!rst_n)
    s2.valid && s2.inst == {`PAL_INST, `PAL_WHAMI} |->
      x_w_out.wb.wr_en && x_w_out.wb.wr_idx == 5'd0 && x_w_out.wb.wr_data == `CPU_ID)
    else report_failure("whami write to r0");

endmodule

bind core_top core_asserts u_asserts (
  .clock   (clock),
  .rst_n   (rst_n),
  .f_d_in  (f_d_in),
  .x_w_out (x_w_out)
);

// ==== testbench/core_tb.sv ====
////////////////////////////////////////////////////////////
// core testbench
// register init, random legal then illegal instructions,
// each followed by two bubbles; checks sit in core_asserts
////////////////////////////////////////////////////////////
`include "id_defs.svh"

module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_INIT       = 31;  // r0..r30
  localparam int N_RAND       = 300;
  localparam int N_ILL        = 40;
  localparam int N_TOTAL      = N_INIT + N_RAND + N_ILL + 2; // + halt, whami
  localparam int RESET_CYCLES = 4;

  // legal operate pairs {opcode, function}
  localparam logic [12:0] OPER_TAB [17] = '{
    {`INTA_GRP, `ADDQ_INST},   {`INTA_GRP, `SUBQ_INST},  {`INTA_GRP, `CMPEQ_INST},
    {`INTA_GRP, `CMPLT_INST},  {`INTA_GRP, `CMPLE_INST}, {`INTA_GRP, `CMPULT_INST},
    {`INTA_GRP, `CMPULE_INST}, {`INTL_GRP, `AND_INST},   {`INTL_GRP, `BIC_INST},
    {`INTL_GRP, `BIS_INST},    {`INTL_GRP, `ORNOT_INST}, {`INTL_GRP, `XOR_INST},
    {`INTL_GRP, `EQV_INST},    {`INTS_GRP, `SRL_INST},   {`INTS_GRP, `SLL_INST},
    {`INTS_GRP, `SRA_INST},    {`INTM_GRP, `MULQ_INST}
  };
  localparam logic [5:0] MEM_OPS [5] = '{`LDA_INST, `LDQ_INST, `LDQ_L_INST,
                                         `STQ_INST, `STQ_C_INST};
  localparam logic [5:0] CBR_OPS [6] = '{`BEQ_INST, `BLT_INST, `BLE_INST,
                                         `BNE_INST, `BGE_INST, `BGT_INST};
  // fp operate, fp load/store, blbc, blbs
  localparam logic [5:0] BAD_OPS [8] = '{6'h14, 6'h16, 6'h17, 6'h20,
                                         6'h23, 6'h27, 6'h38, 6'h3c};

  logic                clock;
  logic                rst_n;
  id_pkg::f_d_packet_t f_d_in;
  id_pkg::x_w_packet_t x_w_out;
  logic [31:0]         rng;     // xorshift state

  core_top dut (
    .clock   (clock),
    .rst_n   (rst_n),
    .f_d_in  (f_d_in),
    .x_w_out (x_w_out)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  ////////////////////////////////////////////////////////////
  // instruction builders
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] random_legal();
    logic [31:0] r;
    logic [31:0] f;
    logic [12:0] pair;
    r    = next_rand();
    f    = next_rand();
    pair = OPER_TAB[f[15:0] % 17];
    case (r[31:29])
      3'd0, 3'd1, 3'd2: return {pair[12:7], r[25:12], pair[6:0], r[4:0]}; // operate
      3'd3:             return {MEM_OPS[f[15:0] % 5], r[25:0]};
      3'd4:             return {f[0] ? `BR_INST : `BSR_INST, r[25:0]};
      3'd5:             return {`JSR_GRP, r[25:0]};
      default:          return {CBR_OPS[f[15:0] % 6], r[25:0]};
    endcase
  endfunction

  function automatic logic [31:0] random_illegal();
    logic [31:0] r;
    logic [31:0] f;
    r = next_rand();
    f = next_rand();
    if (f[1:0] == 2'b00)
      return {`PAL_INST, 1'b1, r[24:0]};            // unused PAL code
    else if (f[1:0] == 2'b01)
      return {`INTA_GRP, r[25:12], 7'h00, r[4:0]};  // addl, longword form
    else
      return {BAD_OPS[f[15:0] % 8], r[25:0]};
  endfunction

  // one instruction then two bubbles, keeps dependents 3 slots apart
  task automatic issue(input logic [31:0] inst);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    @(negedge clock);
    f_d_in.valid = 1'b1;
    f_d_in.inst  = inst;
    f_d_in.npc   = {hi, lo[31:2], 2'b00};  // word aligned
    repeat (2)
    begin
      @(negedge clock);
      f_d_in = '0;                          // bubble
    end
  endtask

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial
  begin
    repeat (N_TOTAL * 3 + 50 + RESET_CYCLES) @(posedge clock);
    stop_with_failure("watchdog expired before the stimulus finished");
  end

  // first failed check ends the run
  initial
  begin
    forever
    begin
      @(negedge clock);
      if (dut.u_asserts.fail_count != 0)
        stop_with_failure("stopping at the first failed check");
    end
  end

  initial
  begin
    logic [31:0] r;
    f_d_in = '0;
    rst_n  = 1'b0;
    rng    = 32'hc20c_5320;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
    repeat (3) @(negedge clock); // idle pipeline after reset
    for (int i = 0; i < N_INIT; i++)
    begin
      r = next_rand();
      issue({`LDA_INST, 5'(i), `ZERO_REG, r[15:0]}); // ri = sext(disp)
    end
    for (int i = 0; i < N_RAND; i++)
      issue(random_legal());
    for (int i = 0; i < N_ILL; i++)
      issue(random_illegal());
    issue({`PAL_INST, `PAL_HALT});
    issue({`PAL_INST, `PAL_WHAMI});
    repeat (4) @(negedge clock); // drain
    if (dut.u_asserts.fail_count == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
      stop_with_failure("checks failed during the run");
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/id_pkg.sv
source/decoder.sv
source/regfile.sv
source/id_stage.sv
source/ex_stage.sv
source/core_top.sv
testbench/core_asserts.sv
testbench/core_tb.sv

// ==== Bender.yml ====
package:
  name: id_ex_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/id_pkg.sv
      - source/decoder.sv
      - source/regfile.sv
      - source/id_stage.sv
      - source/ex_stage.sv
      - source/core_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/core_asserts.sv
      - testbench/core_tb.sv
